//--- src/softmax_fmt_pkg.sv
// Number formats shared by the softmax datapath.
// Inputs and outputs are Q8.8 and the datapath works in Q16.16.

package softmax_fmt_pkg;

    // Fraction bits of the external and internal formats
    localparam int IN_FRAC = 8;
    localparam int Q_FRAC  = 16;

    // Q8.8 element at the ports
    typedef logic signed [15:0] in_elem_t;

    // Q16.16 element inside the engine
    typedef logic signed [31:0] q_elem_t;

    // Four lanes per tile, element 0 in the most significant slot.
    // The tile size of the control side is derived from these types
    typedef in_elem_t [0:3] in_tile_t;
    typedef q_elem_t  [0:3] q_tile_t;

    // log2(e) ~ 1.442695
    localparam q_elem_t LOG2E_Q = 32'sh0001_7154;

    // ln(2) ~ 0.693147
    localparam q_elem_t LN2_Q = 32'sh0000_B172;

    // Start value of the running maximum
    localparam q_elem_t Q_MOST_NEG = 32'sh8000_0000;

endpackage

//--- src/softmax_ctrl_pkg.sv
// Sizes, buffer geometry, engine states and the structs passed between blocks.
// Compiled after the number format package.

package softmax_ctrl_pkg;

    localparam int TILE_SIZE      = $bits(softmax_fmt_pkg::q_tile_t) /
                                    $bits(softmax_fmt_pkg::q_elem_t);
    localparam int TOTAL_ELEMENTS = 32;
    localparam int NUM_TILES      = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int TILE_ADDR_W    = $clog2(NUM_TILES);

    // Q16.16 plus guard bits for the sum of all exponentials
    localparam int SUM_W = $bits(softmax_fmt_pkg::q_elem_t) + 6;

    typedef logic [SUM_W-1:0] sum_t;

    typedef enum logic [2:0] {
        IDLE,
        SUM_PASS,
        LN_STEP,
        OUT_PASS,
        FINISH
    } engine_state_e;

    // Loader write port into the tile buffer
    typedef struct packed {
        logic                     we;
        logic [TILE_ADDR_W-1:0]   addr;
        softmax_fmt_pkg::q_tile_t data;
    } ram_wr_t;

    // End of load pass, carries the vector maximum
    typedef struct packed {
        logic                     loaded;
        softmax_fmt_pkg::q_elem_t max_val;
    } load_summary_t;

endpackage

//--- src/tile_loader.sv
// Load pass: converts Q8.8 tiles to Q16.16, writes them to the tile buffer
// and tracks the running maximum. Pulses the summary once a full vector is in.
`timescale 1ns/1ps

module tile_loader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  softmax_fmt_pkg::in_tile_t      tile_in,
    input  logic                           tile_in_valid,
    input  logic                           busy,
    output softmax_ctrl_pkg::ram_wr_t      wr,
    output softmax_ctrl_pkg::load_summary_t summary
);

    logic                                     accept;
    logic [softmax_ctrl_pkg::TILE_ADDR_W-1:0] tile_cnt;
    softmax_fmt_pkg::q_elem_t                 max_q;
    softmax_fmt_pkg::q_elem_t                 tile_max;
    softmax_fmt_pkg::q_tile_t                 conv_tile;

    logic                                     we_q;
    logic [softmax_ctrl_pkg::TILE_ADDR_W-1:0] addr_q;
    softmax_fmt_pkg::q_tile_t                 data_q;
    logic                                     loaded_q;

    assign accept = tile_in_valid && !busy;

    // Format conversion and max over the tile plus the running max
    always_comb begin
        softmax_fmt_pkg::q_elem_t e;
        tile_max = max_q;
        for (int i = 0; i < softmax_ctrl_pkg::TILE_SIZE; i++) begin
            e = tile_in[i];                                        // Sign extend
            e = e <<< (softmax_fmt_pkg::Q_FRAC - softmax_fmt_pkg::IN_FRAC);
            conv_tile[i] = e;
            if (e > tile_max) begin
                tile_max = e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q     <= 1'b0;
            loaded_q <= 1'b0;
            tile_cnt <= '0;
            max_q    <= softmax_fmt_pkg::Q_MOST_NEG;
        end else begin
            we_q     <= accept;
            loaded_q <= we_q && (int'(addr_q) == softmax_ctrl_pkg::NUM_TILES - 1);
            if (accept) begin
                if (int'(tile_cnt) == softmax_ctrl_pkg::NUM_TILES - 1) begin
                    tile_cnt <= '0;                                // Ready for next vector
                end else begin
                    tile_cnt <= tile_cnt + 1'b1;
                end
                max_q <= tile_max;
            end else if (loaded_q) begin
                max_q <= softmax_fmt_pkg::Q_MOST_NEG;              // Engine has latched it
            end
        end
    end

    // Write payload, qualified by we_q
    always_ff @(posedge clk) begin
        addr_q <= tile_cnt;
        data_q <= conv_tile;
    end

    assign wr      = '{we: we_q, addr: addr_q, data: data_q};
    assign summary = '{loaded: loaded_q, max_val: max_q};

    // Sender must hold off while the engine owns the buffer
    a_no_input_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) !(tile_in_valid && busy)
    );

endmodule

//--- src/tile_ram.sv
// Tile buffer with one write port and one read port.
// Read data is registered and appears one cycle after the address.
`timescale 1ns/1ps

module tile_ram (
    input  logic                                     clk,
    input  softmax_ctrl_pkg::ram_wr_t                wr,
    input  logic [softmax_ctrl_pkg::TILE_ADDR_W-1:0] rd_addr,
    output softmax_fmt_pkg::q_tile_t                 rd_data
);

    softmax_fmt_pkg::q_tile_t mem [softmax_ctrl_pkg::NUM_TILES];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];                                   // Registered read
    end

    // Loader fills the buffer in tile order
    a_wr_addr_in_order: assert property (
        @(posedge clk) (wr.we && $past(wr.we)) |-> (wr.addr == $past(wr.addr) + 1'b1)
    );

endmodule

//--- src/exp_tile.sv
// Approximate exp() of a tile of non-positive Q16.16 values.
// Base-2 range reduction with a linear mantissa, fully combinational.
`timescale 1ns/1ps

module exp_tile (
    input  softmax_fmt_pkg::q_tile_t x,
    output softmax_fmt_pkg::q_tile_t y
);

    // exp(x) = 2^(x*log2e) = 2^n * 2^f, with 2^f ~ 1 + f
    function automatic softmax_fmt_pkg::q_elem_t exp_elem(
        input softmax_fmt_pkg::q_elem_t xe
    );
        logic signed [63:0]       prod;
        softmax_fmt_pkg::q_elem_t t;
        softmax_fmt_pkg::q_elem_t n_neg;
        logic [31:0]              mant;
        prod  = 64'(xe) * 64'(softmax_fmt_pkg::LOG2E_Q);
        t     = prod[softmax_fmt_pkg::Q_FRAC +: 32];               // Back to Q16.16, floors
        n_neg = -(t >>> softmax_fmt_pkg::Q_FRAC);                  // -n, integer part
        mant  = (32'd1 << softmax_fmt_pkg::Q_FRAC) |
                32'(t[softmax_fmt_pkg::Q_FRAC-1:0]);               // 1 + f
        if (n_neg > softmax_fmt_pkg::Q_FRAC) begin
            exp_elem = '0;                                         // Below one LSB
        end else begin
            exp_elem = mant >> n_neg;
        end
    endfunction

    always_comb begin
        for (int i = 0; i < softmax_ctrl_pkg::TILE_SIZE; i++) begin
            y[i] = exp_elem(x[i]);
        end
    end

endmodule

//--- src/ln_unit.sv
// Approximate natural log of the exponential sum.
// ln(s) = ln2 * (k + log2 m), with log2 m ~ m - 1 for m in [1, 2).
`timescale 1ns/1ps

module ln_unit (
    input  softmax_ctrl_pkg::sum_t   sum,
    output softmax_fmt_pkg::q_elem_t ln_val
);

    int                                  lead;
    softmax_ctrl_pkg::sum_t              norm;
    logic [softmax_fmt_pkg::Q_FRAC-1:0]  frac;
    softmax_fmt_pkg::q_elem_t            val;
    logic signed [63:0]                  prod;

    always_comb begin
        lead = 0;
        for (int i = 0; i < softmax_ctrl_pkg::SUM_W; i++) begin
            if (sum[i]) begin
                lead = i;                                          // Highest set bit wins
            end
        end

        // Leading one to the top, the bits under it form the mantissa fraction
        norm = sum << (softmax_ctrl_pkg::SUM_W - 1 - lead);
        frac = norm[softmax_ctrl_pkg::SUM_W-2 -: softmax_fmt_pkg::Q_FRAC];

        // k counts from 1.0, which sits at bit Q_FRAC
        val  = ((lead - softmax_fmt_pkg::Q_FRAC) <<< softmax_fmt_pkg::Q_FRAC) + int'(frac);
        prod = 64'(val) * 64'(softmax_fmt_pkg::LN2_Q);
        ln_val = prod[softmax_fmt_pkg::Q_FRAC +: 32];
    end

endmodule

//--- src/softmax_engine.sv
// Softmax consumer: sum pass, log step and output pass over the tile buffer.
// Three stage pipeline per tile: RAM read, subtract, exp into sum or output.
`timescale 1ns/1ps

module softmax_engine (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  softmax_ctrl_pkg::load_summary_t          summary,
    output logic                                     busy,
    output logic [softmax_ctrl_pkg::TILE_ADDR_W-1:0] rd_addr,
    input  softmax_fmt_pkg::q_tile_t                 rd_data,
    output softmax_fmt_pkg::in_tile_t                tile_out,
    output logic                                     tile_out_valid,
    output logic                                     done
);

    softmax_ctrl_pkg::engine_state_e        state;
    logic [softmax_ctrl_pkg::TILE_ADDR_W:0] addr_cnt;
    logic                                   issue;
    logic [1:0]                             pipe_vld;      // [0] rd_data, [1] diff_q
    logic                                   last_in_exp;

    softmax_fmt_pkg::q_elem_t  max_q;
    softmax_fmt_pkg::q_elem_t  ln_q;
    softmax_fmt_pkg::q_elem_t  ln_val;
    softmax_fmt_pkg::q_elem_t  sub_val;
    softmax_fmt_pkg::q_tile_t  diff_q;
    softmax_fmt_pkg::q_tile_t  exp_y;
    softmax_ctrl_pkg::sum_t    sum_acc;
    softmax_ctrl_pkg::sum_t    tile_sum;
    softmax_fmt_pkg::in_tile_t out_q;
    logic                      out_vld_q;
    logic                      done_q;

    assign issue = (state == softmax_ctrl_pkg::SUM_PASS || state == softmax_ctrl_pkg::OUT_PASS)
                   && (int'(addr_cnt) < softmax_ctrl_pkg::NUM_TILES);
    assign rd_addr = addr_cnt[softmax_ctrl_pkg::TILE_ADDR_W-1:0];

    // Final tile is in the exp stage, nothing behind it
    assign last_in_exp = (int'(addr_cnt) == softmax_ctrl_pkg::NUM_TILES) && (pipe_vld == 2'b10);

    assign busy    = (state != softmax_ctrl_pkg::IDLE) || summary.loaded;
    assign sub_val = (state == softmax_ctrl_pkg::OUT_PASS) ? max_q + ln_q : max_q;

    exp_tile exp_tile_inst (
        .x (diff_q),
        .y (exp_y)
    );

    ln_unit ln_unit_inst (
        .sum    (sum_acc),
        .ln_val (ln_val)
    );

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < softmax_ctrl_pkg::TILE_SIZE; i++) begin
            tile_sum = tile_sum + softmax_ctrl_pkg::sum_t'(exp_y[i]);   // exp is never negative
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= softmax_ctrl_pkg::IDLE;
            addr_cnt  <= '0;
            pipe_vld  <= '0;
            sum_acc   <= '0;
            out_vld_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            pipe_vld  <= {pipe_vld[0], issue};
            out_vld_q <= pipe_vld[1] && (state == softmax_ctrl_pkg::OUT_PASS);
            done_q    <= (state == softmax_ctrl_pkg::FINISH);
            if (issue) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
            if (pipe_vld[1] && state == softmax_ctrl_pkg::SUM_PASS) begin
                sum_acc <= sum_acc + tile_sum;
            end

            case (state)
                softmax_ctrl_pkg::IDLE: begin
                    if (summary.loaded) begin
                        state    <= softmax_ctrl_pkg::SUM_PASS;
                        addr_cnt <= '0;
                        sum_acc  <= '0;
                    end
                end
                softmax_ctrl_pkg::SUM_PASS: begin
                    if (last_in_exp) state <= softmax_ctrl_pkg::LN_STEP;
                end
                softmax_ctrl_pkg::LN_STEP: begin
                    state    <= softmax_ctrl_pkg::OUT_PASS;
                    addr_cnt <= '0;                                // Second sweep of the buffer
                end
                softmax_ctrl_pkg::OUT_PASS: begin
                    if (last_in_exp) state <= softmax_ctrl_pkg::FINISH;
                end
                default: begin
                    state <= softmax_ctrl_pkg::IDLE;               // FINISH, last tile on the output
                end
            endcase
        end
    end

    // Datapath registers, qualified by state and pipe_vld
    always_ff @(posedge clk) begin
        if (state == softmax_ctrl_pkg::IDLE && summary.loaded) begin
            max_q <= summary.max_val;
        end
        if (state == softmax_ctrl_pkg::LN_STEP) begin
            ln_q <= ln_val;
        end
        if (pipe_vld[0]) begin
            for (int i = 0; i < softmax_ctrl_pkg::TILE_SIZE; i++) begin
                diff_q[i] <= rd_data[i] - sub_val;                 // Always <= 0
            end
        end
        if (pipe_vld[1] && state == softmax_ctrl_pkg::OUT_PASS) begin
            for (int i = 0; i < softmax_ctrl_pkg::TILE_SIZE; i++) begin
                out_q[i] <= softmax_fmt_pkg::in_elem_t'(
                    exp_y[i] >>> (softmax_fmt_pkg::Q_FRAC - softmax_fmt_pkg::IN_FRAC));
            end
        end
    end

    assign tile_out       = out_q;
    assign tile_out_valid = out_vld_q;
    assign done           = done_q;

    // Output tiles only while the output pass runs or drains
    a_out_in_out_pass: assert property (
        @(posedge clk) disable iff (!rst_n)
        tile_out_valid |-> (state == softmax_ctrl_pkg::OUT_PASS ||
                            state == softmax_ctrl_pkg::FINISH)
    );

    // done closes the output stream, right behind the last tile
    a_done_after_last_tile: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> ($past(tile_out_valid) && !tile_out_valid)
    );

endmodule

//--- src/softmax_top.sv
// Top level of the tiled softmax.
// Loader fills the tile buffer, the engine reads it back twice and streams the result.
`timescale 1ns/1ps

module softmax_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  softmax_fmt_pkg::in_tile_t tile_in,
    input  logic                      tile_in_valid,
    output softmax_fmt_pkg::in_tile_t tile_out,
    output logic                      tile_out_valid,
    output logic                      done
);

    softmax_ctrl_pkg::ram_wr_t                wr;
    softmax_ctrl_pkg::load_summary_t          summary;
    logic                                     busy;
    logic [softmax_ctrl_pkg::TILE_ADDR_W-1:0] rd_addr;
    softmax_fmt_pkg::q_tile_t                 rd_data;

    tile_loader tile_loader_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .tile_in       (tile_in),
        .tile_in_valid (tile_in_valid),
        .busy          (busy),
        .wr            (wr),
        .summary       (summary)
    );

    tile_ram tile_ram_inst (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    softmax_engine softmax_engine_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .summary        (summary),
        .busy           (busy),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

endmodule

//--- test/softmax_tb.sv
// Testbench for the tiled softmax top level.
// Plays a table of vectors back to back, without reset between runs, and checks each result.
`timescale 1ns/1ps

module softmax_tb;

    localparam int NUM_ENTRIES  = 8;
    localparam int NUM_ELEMS    = 32;
    localparam int NUM_TILES    = 8;
    localparam int TILE_ELEMS   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT  = NUM_ENTRIES * 60;
    localparam int ONE_Q8       = 256;                 // 1.0 in Q8.8
    localparam int PEAK_POS     = 13;
    localparam int PEAK_STEP    = 1024;                // 4.0 in Q8.8
    localparam int RAND_SPAN    = 1024;                // Random elements within +-4.0
    localparam int SUM_LO       = 230;                 // 1.0 - 10 %
    localparam int SUM_HI       = 282;                 // 1.0 + 10 %

    typedef enum {UNIFORM, RANDOM, PEAK, SHIFTED} vec_kind_e;

    typedef struct {
        string     name;
        vec_kind_e kind;
        int        base;                               // Q8.8 offset
    } entry_t;

    logic                      clk;
    logic                      rst_n;
    softmax_fmt_pkg::in_tile_t tile_in;
    logic                      tile_in_valid;
    softmax_fmt_pkg::in_tile_t tile_out;
    logic                      tile_out_valid;
    logic                      done;

    entry_t table_q [NUM_ENTRIES];
    int     vec_in   [NUM_ELEMS];
    int     vec_out  [NUM_ELEMS];
    int     rand_in  [NUM_ELEMS];                      // Last random vector, base for shifted runs
    int     rand_out [NUM_ELEMS];
    int     seed      = 58517;
    int     err_cnt   = 0;
    int     check_cnt = 0;
    int     cycle_cnt = 0;
    int     tile_cnt;
    int     done_cnt;

    softmax_top softmax_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .tile_in        (tile_in),
        .tile_in_valid  (tile_in_valid),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the runs did not complete within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int clamp_int(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    task automatic compare_value(input string test_name, input string what,
                                 input int expected, input int actual);
        check_cnt++;
        if (expected != actual) begin
            err_cnt++;
            $display("** Error [%s] %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic build_vector(input entry_t e);
        for (int i = 0; i < NUM_ELEMS; i++) begin
            case (e.kind)
                UNIFORM: vec_in[i] = e.base;
                RANDOM:  vec_in[i] = e.base + $random(seed) % (RAND_SPAN + 1);
                PEAK:    vec_in[i] = (i == PEAK_POS) ? e.base + PEAK_STEP : e.base;
                default: vec_in[i] = rand_in[i] + e.base;
            endcase
        end
    endtask

    task automatic send_vector();
        softmax_fmt_pkg::in_tile_t tile;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int j = 0; j < TILE_ELEMS; j++) begin
                tile[j] = softmax_fmt_pkg::in_elem_t'(vec_in[t * TILE_ELEMS + j]);
            end
            @(posedge clk);
            tile_in       <= tile;
            tile_in_valid <= 1'b1;
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
        tile_in       <= '0;
    endtask

    // Gathers output tiles until done, then watches a few quiet cycles
    task automatic collect_output();
        tile_cnt = 0;
        done_cnt = 0;
        while (done_cnt == 0) begin
            @(negedge clk);
            if (tile_out_valid) begin
                if (tile_cnt < NUM_TILES) begin
                    for (int j = 0; j < TILE_ELEMS; j++) begin
                        vec_out[tile_cnt * TILE_ELEMS + j] = int'(tile_out[j]);
                    end
                end
                tile_cnt++;
            end
            if (done) done_cnt++;
        end
        repeat (3) begin
            @(negedge clk);
            if (tile_out_valid) tile_cnt++;
            if (done) done_cnt++;
        end
    endtask

    task automatic check_results(input entry_t e);
        int sum;
        int max_v;
        int max_pos;
        int max_num;
        sum     = 0;
        max_v   = vec_out[0];
        max_pos = 0;
        max_num = 0;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            sum += vec_out[i];
            compare_value(e.name, $sformatf("out[%0d] not negative", i),
                          clamp_int(vec_out[i], 0, 32767), vec_out[i]);
            if (vec_out[i] > max_v) begin
                max_v   = vec_out[i];
                max_pos = i;
            end
        end
        for (int i = 0; i < NUM_ELEMS; i++) begin
            if (vec_out[i] == max_v) max_num++;
        end
        case (e.kind)
            UNIFORM: begin
                // Every element gets 1/32, one LSB of slack
                compare_value(e.name, "out[0] near 1/32",
                              clamp_int(vec_out[0], ONE_Q8 / NUM_ELEMS - 1,
                                        ONE_Q8 / NUM_ELEMS + 1), vec_out[0]);
                for (int i = 1; i < NUM_ELEMS; i++) begin
                    compare_value(e.name, $sformatf("out[%0d] equal to out[0]", i),
                                  vec_out[0], vec_out[i]);
                end
            end
            RANDOM: begin
                compare_value(e.name, "sum of outputs", clamp_int(sum, SUM_LO, SUM_HI), sum);
                rand_in  = vec_in;
                rand_out = vec_out;
            end
            PEAK: begin
                compare_value(e.name, "position of largest output", PEAK_POS, max_pos);
                compare_value(e.name, "count of largest outputs", 1, max_num);
            end
            default: begin
                for (int i = 0; i < NUM_ELEMS; i++) begin
                    compare_value(e.name, $sformatf("out[%0d] vs unshifted", i),
                                  rand_out[i], vec_out[i]);
                end
            end
        endcase
    endtask

    initial begin
        rst_n         <= 1'b0;
        tile_in       <= '0;
        tile_in_valid <= 1'b0;

        // Shifted entries reuse the random vector right before them
        table_q[0] = '{"uniform_zero", UNIFORM, 0};
        table_q[1] = '{"uniform_neg",  UNIFORM, -768};
        table_q[2] = '{"random_a",     RANDOM,  0};
        table_q[3] = '{"shifted_a",    SHIFTED, 640};
        table_q[4] = '{"peak_zero",    PEAK,    0};
        table_q[5] = '{"random_b",     RANDOM,  0};
        table_q[6] = '{"shifted_b",    SHIFTED, -1280};
        table_q[7] = '{"peak_neg",     PEAK,    -512};

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        repeat (8) begin
            @(negedge clk);
            if (tile_out_valid || done) begin
                err_cnt++;
                $display("Output strobe went high after reset before any input was sent");
            end
        end

        for (int k = 0; k < NUM_ENTRIES; k++) begin
            build_vector(table_q[k]);
            send_vector();
            collect_output();
            if (tile_cnt != NUM_TILES) begin
                err_cnt++;
                $display("%s: received %0d output tiles instead of %0d",
                         table_q[k].name, tile_cnt, NUM_TILES);
            end
            if (done_cnt != 1) begin
                err_cnt++;
                $display("%s: saw %0d done pulses instead of one", table_q[k].name, done_cnt);
            end
            check_results(table_q[k]);
        end

        $display("Runs: %0d, checks: %0d, errors: %0d", NUM_ENTRIES, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
src/softmax_fmt_pkg.sv
src/softmax_ctrl_pkg.sv
src/tile_loader.sv
src/tile_ram.sv
src/exp_tile.sv
src/ln_unit.sv
src/softmax_engine.sv
src/softmax_top.sv
test/softmax_tb.sv

//--- Makefile
# Verilator build and run of the softmax testbench

SRCS := $(shell cat compile.f)

all: run

obj_dir/Vsoftmax_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module softmax_tb \
		-f compile.f -o Vsoftmax_tb

run: obj_dir/Vsoftmax_tb
	obj_dir/Vsoftmax_tb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
